// File: rtl/componentCountLoop.sv
`default_nettype none

module componentCountLoop import connectCountPkg::*; #(
    parameter int TAG_WIDTH = 8
) (
    input logic clk,
    input logic rstN,
    input logic start,
    input logic [GRAPH_BITS-1:0] graph,
    input logic [TAG_WIDTH-1:0] tag,
    output logic request,
    output logic done,
    output logic [COUNT_WIDTH-1:0] count,
    output logic [TAG_WIDTH-1:0] tagOut,
    explorationIf.loop explore
);

    localparam int STATE_BITS = $bits(slotState);
    localparam int RING_WIDTH = STATE_BITS + COUNT_WIDTH + TAG_WIDTH;
    localparam int SEED_CYCLES = 2;
    // whatever is left after loop-back, input and seed registers
    localparam int EXPLORE_CYCLES = LOOP_LATENCY - SEED_CYCLES - 2;

    slotState lbState;
    logic lbFinish;
    logic [GRAPH_BITS-1:0] lbLeftover;
    logic [GRAPH_BITS-1:0] lbExtension;
    logic [COUNT_WIDTH-1:0] lbCount;
    logic [TAG_WIDTH-1:0] lbTag;
    logic accept;
    slotState inState;
    logic [GRAPH_BITS-1:0] inLeftover;
    logic [GRAPH_BITS-1:0] inExtension;
    logic [COUNT_WIDTH-1:0] inCount;
    logic [TAG_WIDTH-1:0] inTag;
    logic [GRAPH_BITS-1:0] seed;
    logic nonEmpty;
    logic [GRAPH_BITS-1:0] seedLeftover;
    logic [GRAPH_BITS-1:0] seedExtension;
    logic [RING_WIDTH-1:0] seedRing;
    slotState seedState;
    logic [COUNT_WIDTH-1:0] seedCount;
    logic [TAG_WIDTH-1:0] seedTag;
    slotState midState;
    logic [COUNT_WIDTH-1:0] midCount;
    logic [RING_WIDTH-1:0] endRing;
    slotState endState;
    logic [COUNT_WIDTH-1:0] endCount;
    logic [TAG_WIDTH-1:0] endTag;

    // the slot now at the ring input is the loop-back register
    assign request = (lbState == slotFree);
    assign accept = start && request;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            inState <= slotFree;
        end else begin
            inState <= accept ? slotSeed : lbState;
        end
    end

    always_ff @(posedge clk) begin
        inLeftover <= accept ? graph : lbLeftover;
        inExtension <= lbExtension;
        inCount <= accept ? '0 : lbCount;
        inTag <= accept ? tag : lbTag;
    end

    firstBitFinder seedFinder (
        .clk(clk),
        .graph(inLeftover),
        .seed(seed),
        .nonEmpty(nonEmpty)
    );

    delayLine #(
        .CYCLES(SEED_CYCLES),
        .WIDTH(2*GRAPH_BITS)
    ) extensionDelay (
        .clk(clk),
        .rstN(rstN),
        .d({inLeftover, inExtension}),
        .q({seedLeftover, seedExtension})
    );

    delayLine #(
        .CYCLES(SEED_CYCLES),
        .WIDTH(RING_WIDTH)
    ) seedRingDelay (
        .clk(clk),
        .rstN(rstN),
        .d({inState, inCount, inTag}),
        .q(seedRing)
    );

    assign seedState = slotState'(seedRing[RING_WIDTH-1 -: STATE_BITS]);
    assign seedCount = seedRing[TAG_WIDTH +: COUNT_WIDTH];
    assign seedTag = seedRing[TAG_WIDTH-1:0];

    // seed point, a fresh seed starts the next component
    assign explore.leftover = seedLeftover;
    assign explore.curExtending = (seedState == slotSeed) ? seed : seedExtension;
    assign midState = (seedState == slotFree) ? slotFree : slotExtend;
    assign midCount = seedCount + COUNT_WIDTH'(seedState == slotSeed && nonEmpty);

    delayLine #(
        .CYCLES(EXPLORE_CYCLES),
        .WIDTH(RING_WIDTH)
    ) exploreRingDelay (
        .clk(clk),
        .rstN(rstN),
        .d({midState, midCount, seedTag}),
        .q(endRing)
    );

    assign endState = slotState'(endRing[RING_WIDTH-1 -: STATE_BITS]);
    assign endCount = endRing[TAG_WIDTH +: COUNT_WIDTH];
    assign endTag = endRing[TAG_WIDTH-1:0];

    // loop-back register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            lbState <= slotFree;
            lbFinish <= 1'b0;
        end else begin
            lbFinish <= (endState != slotFree) && explore.runEnd;
            if (endState == slotFree || explore.runEnd) begin
                lbState <= slotFree;
            end else if (explore.grabNewSeed) begin
                lbState <= slotSeed;
            end else begin
                lbState <= slotExtend;
            end
        end
    end

    // reduced plus extended rebuilds the leftover graph while still extending
    always_ff @(posedge clk) begin
        lbLeftover <= explore.grabNewSeed ? explore.reduced
                                          : (explore.reduced | explore.extended);
        lbExtension <= explore.extended;
        lbCount <= endCount;
        lbTag <= endTag;
    end

    // result register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            done <= 1'b0;
        end else begin
            done <= lbFinish;
        end
    end

    always_ff @(posedge clk) begin
        count <= lbCount;
        tagOut <= lbTag;
    end

endmodule

`default_nettype wire

// File: rtl/connectCountPkg.sv
`default_nettype none

package connectCountPkg;

    // one bit per element of the 7-variable lattice
    parameter int GRAPH_BITS = 128;

    // wide enough for the worst case of 128 isolated elements
    parameter int COUNT_WIDTH = 8;

    // cycles for one trip round the ring, equal to the number of slots
    parameter int LOOP_LATENCY = 10;

    // slotFree must stay at encoding zero, the ring clears to it
    typedef enum logic [1:0] {
        slotFree,
        slotSeed,
        slotExtend
    } slotState;

endpackage

`default_nettype wire

// File: rtl/connectCountTop.sv
`default_nettype none

module connectCountTop import connectCountPkg::*; #(
    parameter int TAG_WIDTH = 8
) (
    input logic clk,
    input logic rstN,
    input logic start,
    output logic request,
    output logic done,
    input logic [GRAPH_BITS-1:0] graph,
    input logic [TAG_WIDTH-1:0] tag,
    output logic [COUNT_WIDTH-1:0] count,
    output logic [TAG_WIDTH-1:0] tagOut
);

    // bundle between the ring and the up/down extension step
    explorationIf exploreBus ();

    componentCountLoop #(
        .TAG_WIDTH(TAG_WIDTH)
    ) ringLoop (
        .clk(clk),
        .rstN(rstN),
        .start(start),
        .graph(graph),
        .tag(tag),
        .request(request),
        .done(done),
        .count(count),
        .tagOut(tagOut),
        .explore(exploreBus.loop)
    );

    explorationStage explorer (
        .clk(clk),
        .rstN(rstN),
        .bus(exploreBus.explore)
    );

endmodule

`default_nettype wire

// File: rtl/delayLine.sv
`default_nettype none

module delayLine #(
    parameter int CYCLES = 1,
    parameter int WIDTH = 1
) (
    input logic clk,
    input logic rstN,
    input logic [WIDTH-1:0] d,
    output logic [WIDTH-1:0] q
);

    logic [WIDTH-1:0] stages [CYCLES];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < CYCLES; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= d;
            // shift towards the last stage
            for (int i = 1; i < CYCLES; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign q = stages[CYCLES-1];

endmodule

`default_nettype wire

// File: rtl/explorationIf.sv
`default_nettype none

interface explorationIf import connectCountPkg::*; ();

    logic [GRAPH_BITS-1:0] leftover;
    logic [GRAPH_BITS-1:0] curExtending;
    logic [GRAPH_BITS-1:0] extended;
    logic [GRAPH_BITS-1:0] reduced;
    logic runEnd;
    logic grabNewSeed;

    // ring side
    modport loop (
        output leftover, curExtending,
        input extended, reduced, runEnd, grabNewSeed
    );

    // exploration side
    modport explore (
        input leftover, curExtending,
        output extended, reduced, runEnd, grabNewSeed
    );

endinterface

`default_nettype wire

// File: rtl/explorationStage.sv
`default_nettype none

module explorationStage import connectCountPkg::*; (
    input logic clk,
    input logic rstN,
    explorationIf.explore bus
);

    logic [GRAPH_BITS-1:0] upClosed;
    logic [GRAPH_BITS-1:0] leftoverUp;
    logic [GRAPH_BITS-1:0] midpoint;
    logic [GRAPH_BITS-1:0] leftoverMid;
    logic [GRAPH_BITS-1:0] downClosed;
    logic [GRAPH_BITS-1:0] midpointDown;
    logic [GRAPH_BITS-1:0] leftoverDown;
    logic [GRAPH_BITS-1:0] extendedNext;
    logic [GRAPH_BITS-1:0] reducedNext;
    logic [GRAPH_BITS/16-1:0] reducedAny;
    logic [GRAPH_BITS/8-1:0] byteSame;

    // cycles 1 and 2
    latticeClosure #(
        .UPWARD(1'b1)
    ) upClosure (
        .clk(clk),
        .d(bus.curExtending),
        .q(upClosed)
    );

    delayLine #(
        .CYCLES(2),
        .WIDTH(GRAPH_BITS)
    ) leftoverDelay (
        .clk(clk),
        .rstN(rstN),
        .d(bus.leftover),
        .q(leftoverUp)
    );

    // cycle 3, everything above the extension that is still in the graph
    always_ff @(posedge clk) begin
        midpoint <= upClosed & leftoverUp;
        leftoverMid <= leftoverUp;
    end

    // cycles 4 and 5
    latticeClosure #(
        .UPWARD(1'b0)
    ) downClosure (
        .clk(clk),
        .d(midpoint),
        .q(downClosed)
    );

    delayLine #(
        .CYCLES(2),
        .WIDTH(2*GRAPH_BITS)
    ) midpointDelay (
        .clk(clk),
        .rstN(rstN),
        .d({midpoint, leftoverMid}),
        .q({midpointDown, leftoverDown})
    );

    assign extendedNext = leftoverDown & downClosed;
    assign reducedNext = leftoverDown & ~downClosed;

    // cycle 6
    always_ff @(posedge clk) begin
        bus.extended <= extendedNext;
        bus.reduced <= reducedNext;
    end

    // partial reductions, finished combinationally after the register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            reducedAny <= '0;
            byteSame <= '0;
        end else begin
            for (int i = 0; i < GRAPH_BITS/16; i++) begin
                reducedAny[i] <= |reducedNext[16*i +: 16];
            end
            for (int i = 0; i < GRAPH_BITS/8; i++) begin
                byteSame[i] <= extendedNext[8*i +: 8] == midpointDown[8*i +: 8];
            end
        end
    end

    assign bus.runEnd = ~|reducedAny;
    // no growth means the component is closed
    // an empty remainder also ends the component
    assign bus.grabNewSeed = (&byteSame) | bus.runEnd;

endmodule

`default_nettype wire

// File: rtl/firstBitFinder.sv
`default_nettype none

module firstBitFinder import connectCountPkg::*; (
    input logic clk,
    input logic [GRAPH_BITS-1:0] graph,
    output logic [GRAPH_BITS-1:0] seed,
    output logic nonEmpty
);

    localparam int NIBBLES = GRAPH_BITS / 4;
    localparam int GROUPS = GRAPH_BITS / 16;

    logic [GRAPH_BITS-1:0] graphHeld;
    logic [NIBBLES-1:0] nibbleHas;
    logic [GROUPS-1:0] groupHas;
    logic [GROUPS-1:0] firstGroup;
    logic [NIBBLES-1:0] firstNibble;
    logic [GRAPH_BITS-1:0] seedNext;

    // stage one, occupancy per nibble and per 16-bit group
    always_ff @(posedge clk) begin
        graphHeld <= graph;
        for (int n = 0; n < NIBBLES; n++) begin
            nibbleHas[n] <= |graph[4*n +: 4];
        end
        for (int g = 0; g < GROUPS; g++) begin
            groupHas[g] <= |graph[16*g +: 16];
        end
    end

    // lowest occupied group over the whole graph
    always_comb begin
        logic lowerSet;
        lowerSet = 1'b0;
        for (int g = 0; g < GROUPS; g++) begin
            firstGroup[g] = groupHas[g] & ~lowerSet;
            lowerSet = lowerSet | groupHas[g];
        end
    end

    // lowest occupied nibble, only inside the chosen group
    always_comb begin
        logic lowerSet;
        lowerSet = 1'b0;
        for (int n = 0; n < NIBBLES; n++) begin
            if (n % 4 == 0)
                lowerSet = 1'b0;
            firstNibble[n] = nibbleHas[n] & ~lowerSet & firstGroup[n/4];
            lowerSet = lowerSet | nibbleHas[n];
        end
    end

    // final bit inside the chosen nibble
    always_comb begin
        logic lowerSet;
        lowerSet = 1'b0;
        for (int b = 0; b < GRAPH_BITS; b++) begin
            if (b % 4 == 0)
                lowerSet = 1'b0;
            seedNext[b] = graphHeld[b] & ~lowerSet & firstNibble[b/4];
            lowerSet = lowerSet | graphHeld[b];
        end
    end

    always_ff @(posedge clk) begin
        seed <= seedNext;
        nonEmpty <= (|groupHas[GROUPS/2-1:0]) | (|groupHas[GROUPS-1:GROUPS/2]);
    end

endmodule

`default_nettype wire

// File: rtl/latticeClosure.sv
`default_nettype none

module latticeClosure import connectCountPkg::*; #(
    parameter bit UPWARD = 1'b1
) (
    input logic clk,
    input logic [GRAPH_BITS-1:0] d,
    output logic [GRAPH_BITS-1:0] q
);

    localparam int LATTICE_DIMS = $clog2(GRAPH_BITS);
    localparam int SPLIT_DIM = 4;
    // source elements have this value in the dimension being spread
    localparam int FROM_BIT = UPWARD ? 0 : 1;

    logic [GRAPH_BITS-1:0] lowDims;
    logic [GRAPH_BITS-1:0] stageOne;
    logic [GRAPH_BITS-1:0] highDims;

    // push every element across dimension k in the closure direction
    function automatic logic [GRAPH_BITS-1:0] spreadDim(
        input logic [GRAPH_BITS-1:0] v,
        input int k
    );
        logic [GRAPH_BITS-1:0] r;
        int partner;
        r = v;
        for (int i = 0; i < GRAPH_BITS; i++) begin
            partner = i ^ (1 << k);
            if (((i >> k) & 1) == FROM_BIT) begin
                r[partner] = r[partner] | v[i];
            end
        end
        return r;
    endfunction

    // dimensions 0 to 3
    always_comb begin
        lowDims = d;
        for (int k = 0; k < SPLIT_DIM; k++) begin
            lowDims = spreadDim(lowDims, k);
        end
    end

    always_ff @(posedge clk) begin
        stageOne <= lowDims;
    end

    // dimensions 4 to 6 finish the monotone closure
    always_comb begin
        highDims = stageOne;
        for (int k = SPLIT_DIM; k < LATTICE_DIMS; k++) begin
            highDims = spreadDim(highDims, k);
        end
    end

    always_ff @(posedge clk) begin
        q <= highDims;
    end

endmodule

`default_nettype wire

// File: test/connectCountTb.sv
`default_nettype none

module connectCountTb import connectCountPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TAG_WIDTH = 8;
    localparam int NUM_VECTORS = 25;
    localparam int VECTOR_BITS = TAG_WIDTH + GRAPH_BITS + COUNT_WIDTH;
    // up to 128 components per graph, each a few trips round the ring
    localparam int TIMEOUT_CYCLES = NUM_VECTORS * 140 * LOOP_LATENCY;
    localparam int RESET_CYCLES = 5;
    // never used by the data file
    localparam logic [TAG_WIDTH-1:0] DECOY_TAG = '1;

    logic clk;
    logic rstN;
    logic start;
    logic [GRAPH_BITS-1:0] graph;
    logic [TAG_WIDTH-1:0] tag;
    logic request;
    logic done;
    logic [COUNT_WIDTH-1:0] count;
    logic [TAG_WIDTH-1:0] tagOut;

    logic [VECTOR_BITS-1:0] vectors [NUM_VECTORS];
    logic [COUNT_WIDTH-1:0] expCount [2**TAG_WIDTH];
    bit tagIssued [2**TAG_WIDTH];
    bit tagSeen [2**TAG_WIDTH];
    int errorCount = 0;
    int resultsSeen = 0;
    int cycleCount = 0;
    int issued = 0;
    integer seed;

    connectCountTop #(
        .TAG_WIDTH(TAG_WIDTH)
    ) i_dut (
        .clk(clk),
        .rstN(rstN),
        .start(start),
        .request(request),
        .done(done),
        .graph(graph),
        .tag(tag),
        .count(count),
        .tagOut(tagOut)
    );

    bind connectCountTop connectCountChecker #(
        .TAG_WIDTH(TAG_WIDTH)
    ) handshakeChecks (
        .clk(clk),
        .rstN(rstN),
        .start(start),
        .request(request),
        .done(done),
        .tag(tag),
        .tagOut(tagOut)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // one line of the data file is {tag, graph, expected count}
    task automatic driveVector(input int idx);
        logic [VECTOR_BITS-1:0] v;
        v = vectors[idx];
        tag = v[VECTOR_BITS-1 -: TAG_WIDTH];
        graph = v[COUNT_WIDTH +: GRAPH_BITS];
        expCount[tag] = v[COUNT_WIDTH-1:0];
        tagIssued[tag] = 1'b1;
        start = 1'b1;
    endtask

    task automatic checkResult(input logic [TAG_WIDTH-1:0] t, input logic [COUNT_WIDTH-1:0] c);
        if ($isunknown(t) || $isunknown(c)) begin
            $display("Error: done with unknown tag or count (tag %h, count %h)", t, c);
            errorCount++;
        end else if (!tagIssued[t]) begin
            $display("Error: result for tag %h that was never started", t);
            errorCount++;
        end else if (tagSeen[t]) begin
            $display("Error: tag %h came back a second time", t);
            errorCount++;
        end else begin
            tagSeen[t] = 1'b1;
            resultsSeen++;
            if (c !== expCount[t]) begin
                $display("Mismatch: count for tag %h expected %h got %h", t, expCount[t], c);
                errorCount++;
            end
        end
    endtask

    task automatic reportMissing();
        for (int i = 0; i < 2**TAG_WIDTH; i++) begin
            if (tagIssued[i] && !tagSeen[i]) begin
                $display("Error: tag %h was started but no result came back", i[TAG_WIDTH-1:0]);
                errorCount++;
            end
        end
    endtask

    // results are sampled away from the rising edge
    always @(negedge clk) begin
        if (rstN && done) begin
            checkResult(tagOut, count);
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Error: timeout after %0d cycles, %0d of %0d results seen",
                     cycleCount, resultsSeen, NUM_VECTORS);
            errorCount++;
            reportMissing();
            $display("Summary: %0d errors, %0d of %0d results checked",
                     errorCount, resultsSeen, NUM_VECTORS);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rstN = 1'b0;
        start = 1'b0;
        graph = '0;
        tag = '0;
        seed = 80199;
        $readmemh("test/connectCount_testdata.txt", vectors);
        repeat (RESET_CYCLES) @(negedge clk);
        rstN = 1'b1;

        // idle ring before the first start
        repeat (3) begin
            @(negedge clk);
            if (done !== 1'b0) begin
                $display("Mismatch: done after reset expected 0 got %h", done);
                errorCount++;
            end
            if (request !== 1'b1) begin
                $display("Mismatch: request after reset expected 1 got %h", request);
                errorCount++;
            end
        end

        // first ring's worth back to back, random idle gaps after that
        while (issued < NUM_VECTORS) begin
            @(negedge clk);
            start = 1'b0;
            if (issued >= LOOP_LATENCY && ($random(seed) & 3) == 0) begin
                start = 1'b0;
            end else if (request) begin
                driveVector(issued);
                issued++;
            end else begin
                // slot at the ring input is busy, this start must be ignored
                tag = DECOY_TAG;
                graph = '0;
                start = 1'b1;
            end
        end
        @(negedge clk);
        start = 1'b0;

        wait (resultsSeen == NUM_VECTORS);
        // late duplicates would show up within a couple of trips
        repeat (2 * LOOP_LATENCY) @(negedge clk);
        reportMissing();
        errorCount += i_dut.handshakeChecks.assertFailures;

        $display("Summary: %0d errors, %0d of %0d results checked",
                 errorCount, resultsSeen, NUM_VECTORS);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/connectCount_checker.sv
`default_nettype none

module connectCountChecker #(
    parameter int TAG_WIDTH = 8
) (
    input logic clk,
    input logic rstN,
    input logic start,
    input logic request,
    input logic done,
    input logic [TAG_WIDTH-1:0] tag,
    input logic [TAG_WIDTH-1:0] tagOut
);

    timeunit 1ns;
    timeprecision 100ps;

    // failures seen so far, read by the testbench at the end
    int assertFailures = 0;

    logic ignoredValid;
    logic [TAG_WIDTH-1:0] ignoredTag;

    // tag of the last start made while request was low
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ignoredValid <= 1'b0;
            ignoredTag <= '0;
        end else if (start && !request) begin
            ignoredValid <= 1'b1;
            ignoredTag <= tag;
        end
    end

    // handshake outputs are never unknown once out of reset
    outputsKnown: assert property (
        @(posedge clk) disable iff (!rstN) !$isunknown({done, request})
    ) else begin
        assertFailures++;
        $error("done or request is unknown after reset");
    end

    // a start while the ring input slot is busy never yields a result
    startIgnored: assert property (
        @(posedge clk) disable iff (!rstN) done && ignoredValid |-> tagOut != ignoredTag
    ) else begin
        assertFailures++;
        $error("start accepted while request was low");
    end

    // back to back results are allowed, one result held twice is not
    donePulse: assert property (
        @(posedge clk) disable iff (!rstN) done |=> !done || tagOut != $past(tagOut)
    ) else begin
        assertFailures++;
        $error("done held high for more than one cycle");
    end

endmodule

`default_nettype wire

// File: test/connectCount_testdata.txt
// columns: tag (2 hex) _ graph bits 127..0 (8 groups of 4 hex) _ expected count (2 hex)
// bit i of the graph is the lattice element with code i
01_0000_0000_0000_0000_0000_0000_0000_0000_00
02_0000_0000_0000_0000_0000_0000_0000_0020_01
03_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF_01
04_0001_0116_0116_1668_0116_1668_1668_6880_23
05_0000_0001_0001_0116_0001_0116_0116_1668_15
06_0001_0117_0117_177E_0117_177E_177E_7EE8_01
07_8000_0000_0000_0000_0000_0000_0000_0000_01
08_8000_0000_0000_0000_0000_0000_0000_0001_01
09_0000_0000_0000_0000_0000_0000_0000_115E_01
0A_0000_0001_0000_0001_0001_0001_0001_005E_02
0B_0000_0000_0000_0001_0000_0001_0001_0116_07
0C_0000_0000_0000_0001_0000_0001_0001_0117_01
0D_6880_8000_8000_0000_8000_0000_0000_0000_07
0E_6880_8000_8000_0001_8000_0001_0001_0116_01
0F_0001_0116_0116_1668_0116_1668_1668_E880_20
10_0001_0116_0116_1668_0116_1668_1668_6888_1F
11_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFE_01
12_7FFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFE_01
13_0000_0000_0000_0000_0001_0001_0001_6996_02
14_0000_0001_0000_0001_0001_0001_0101_115E_01
15_0001_0000_0001_0000_0000_0000_0000_0420_03
16_AAAA_AAAA_AAAA_AAAA_AAAA_AAAA_AAAA_AAAA_01
17_0116_1668_1668_6880_1668_6880_6880_8000_23
18_1668_6880_6880_8000_6880_8000_8000_0000_15
19_177E_7EE8_7EE8_E880_7EE8_E880_E880_8000_01

// File: vlog.f
rtl/connectCountPkg.sv
rtl/explorationIf.sv
rtl/delayLine.sv
rtl/firstBitFinder.sv
rtl/latticeClosure.sv
rtl/explorationStage.sv
rtl/componentCountLoop.sv
rtl/connectCountTop.sv
test/connectCount_checker.sv
test/connectCountTb.sv
